//--- hazardCtrl.f
logic/hazardPkg.sv
logic/stageTracker.sv
logic/forwardUnit.sv
logic/stallUnit.sv
logic/memHandshake.sv
logic/hazardTop.sv
verif/hazardTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the hazardCtrl testbench with Verilator and run it
# the run passes only if the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module hazardTb \
  -f hazardCtrl.f -o hazardSim \
  && ./obj_dir/hazardSim | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: build or simulation failed"; exit 1; }

//--- verif/hazardTb.sv
`timescale 1ns/1ps

// random testbench for the hazard control block
// a cycle model of the tracker, rules and handshake runs beside the DUT
module hazardTb;

  localparam int HalfPeriod  = 4;
  localparam int ClkPeriod   = 2 * HalfPeriod;
  localparam int ResetCycles = 16;
  localparam int NumCycles   = 3000;

  logic                  clk;
  logic                  arstN;
  hazardPkg::instrInfo_t decodeInstr;
  logic                  branchTakenE;
  logic                  dataAck;
  hazardPkg::fwdSel_e    forwardA;
  hazardPkg::fwdSel_e    forwardB;
  hazardPkg::pipeCtrl_t  ctrl;
  logic                  dataReq;
  hazardPkg::instrInfo_t retireInstr;

  integer seed = 50760;

  // model pipe entries and handshake phase
  hazardPkg::instrInfo_t mEx;
  hazardPkg::instrInfo_t mMem;
  hazardPkg::instrInfo_t mWb;
  hazardPkg::hsState_e   mHs;

  // expected outputs of the current cycle
  hazardPkg::pipeCtrl_t expCtrl;
  hazardPkg::fwdSel_e   expFwdA;
  hazardPkg::fwdSel_e   expFwdB;
  logic                 expReq;
  logic                 expBusy;
  logic                 expLoadUse;

  // instructions that entered execute in program order
  hazardPkg::instrInfo_t retireQ[$];

  // ack responder wait and handshake history
  int   ackWait;
  logic prevReq;
  logic prevAck;
  logic reqSeenForEntry;
  logic draining;
  string testName;

  // number of times each hazard class was seen
  int loadUseCount;
  int branchCount;
  int accessCount;
  int retireCount;

  hazardTop hazardTop_i (
    .clk          (clk),
    .arstN        (arstN),
    .decodeInstr  (decodeInstr),
    .branchTakenE (branchTakenE),
    .dataAck      (dataAck),
    .forwardA     (forwardA),
    .forwardB     (forwardB),
    .ctrl         (ctrl),
    .dataReq      (dataReq),
    .retireInstr  (retireInstr)
  );

  always #HalfPeriod clk = ~clk;

  task automatic failRun(input string what);
    $display("%s", what);
    $display("model handshake state %s", mHs.name());
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  function automatic string fmtInstr(input hazardPkg::instrInfo_t e);
    return $sformatf("v=%0b s1=%0d s2=%0d d=%0d w=%0b ld=%0b st=%0b",
                     e.valid, e.src1, e.src2, e.dst, e.regWrite, e.memRead, e.memWrite);
  endfunction

  task automatic checkFwd(input string name, input hazardPkg::fwdSel_e exp,
                          input hazardPkg::fwdSel_e act);
    if (exp != act)
      failRun($sformatf("[ERROR] %s %s: expected %s, actual %s",
                        testName, name, exp.name(), act.name()));
  endtask

  // bit order stallF stallD stallE stallM flushD flushE flushW
  task automatic checkCtrl(input string name, input hazardPkg::pipeCtrl_t exp,
                           input hazardPkg::pipeCtrl_t act);
    if (exp != act)
      failRun($sformatf("[ERROR] %s %s: expected %b, actual %b", testName, name, exp, act));
  endtask

  task automatic checkInstr(input string name, input hazardPkg::instrInfo_t exp,
                            input hazardPkg::instrInfo_t act);
    if (exp != act)
      failRun($sformatf("[ERROR] %s %s: expected %s, actual %s",
                        testName, name, fmtInstr(exp), fmtInstr(act)));
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (exp !== act)
      failRun($sformatf("[ERROR] %s %s: expected %b, actual %b", testName, name, exp, act));
  endtask

  function automatic logic isAccess(input hazardPkg::instrInfo_t e);
    return e.valid && (e.memRead || e.memWrite);
  endfunction

  // newest writer wins and register 0 never forwards
  function automatic hazardPkg::fwdSel_e expectFwd(input logic [hazardPkg::RegIdxW-1:0] src);
    logic memHit;
    logic wbHit;
    memHit = mMem.valid && mMem.regWrite && (mMem.dst == src) && (src != '0);
    wbHit  = mWb.valid && mWb.regWrite && (mWb.dst == src) && (src != '0);
    if (memHit)
      return hazardPkg::fwdMem;
    if (wbHit)
      return hazardPkg::fwdWb;
    return hazardPkg::fwdNone;
  endfunction

  // small register numbers so that matches are frequent
  function automatic hazardPkg::instrInfo_t randomInstr();
    hazardPkg::instrInfo_t d;
    logic [31:0] r;
    r = $random(seed);
    d = '0;
    d.valid      = (r[1:0] != 2'b00);
    d.src1[1:0]  = r[3:2];
    d.src2[1:0]  = r[5:4];
    d.dst[1:0]   = r[7:6];
    d.memRead    = (r[11:9] < 3'd2);
    d.memWrite   = !d.memRead && (r[11:9] == 3'd2);
    // loads always write and stores never do
    d.regWrite   = d.memRead || (!d.memWrite && r[8]);
    return d;
  endfunction

  // combinational rules of the current cycle
  task automatic computeExpected();
    logic pending;
    logic srcHit;
    pending    = isAccess(mMem);
    expBusy    = ((mHs == hazardPkg::hsIdle) && pending) ||
                 (mHs == hazardPkg::hsReq) || (mHs == hazardPkg::hsRelease);
    expReq     = (mHs == hazardPkg::hsReq);
    srcHit     = (mEx.dst == decodeInstr.src1) || (mEx.dst == decodeInstr.src2);
    expLoadUse = decodeInstr.valid && mEx.valid && mEx.memRead && (mEx.dst != '0) && srcHit;
    expCtrl.stallF = expLoadUse || expBusy;
    expCtrl.stallD = expLoadUse || expBusy;
    expCtrl.stallE = expBusy;
    expCtrl.stallM = expBusy;
    expCtrl.flushD = branchTakenE && !expBusy;
    expCtrl.flushE = (expLoadUse || branchTakenE) && !expBusy;
    expCtrl.flushW = expBusy;
    expFwdA = expectFwd(mEx.src1);
    expFwdB = expectFwd(mEx.src2);
  endtask

  // one rising edge of the model
  task automatic advanceModel();
    hazardPkg::hsState_e hsNext;
    hsNext = mHs;
    case (mHs)
      hazardPkg::hsIdle:
        if (isAccess(mMem))
          hsNext = hazardPkg::hsReq;
      hazardPkg::hsReq:
        if (dataAck)
          hsNext = hazardPkg::hsRelease;
      hazardPkg::hsRelease:
        if (!dataAck)
          hsNext = hazardPkg::hsDone;
      default:
        if (!expCtrl.stallM)
          hsNext = hazardPkg::hsIdle;
    endcase
    if (expCtrl.stallM)
    begin
      // execute and memory hold while writeback gets a bubble
      mWb       = mMem;
      mWb.valid = 1'b0;
    end
    else
    begin
      mWb             = mMem;
      mMem            = mEx;
      reqSeenForEntry = 1'b0;
      mEx             = decodeInstr;
      if (expCtrl.flushE || expCtrl.stallD)
        mEx.valid = 1'b0;
      else if (decodeInstr.valid)
        retireQ.push_back(decodeInstr);
    end
    mHs = hsNext;
  endtask

  // falling edge drive with the responder first since it reads dataReq
  task automatic driveInputs();
    logic [31:0] rb;
    if (!dataAck && dataReq)
    begin
      if (ackWait == 0)
      begin
        dataAck = 1'b1;
        ackWait = $random(seed) & 3;
      end
      else
        ackWait = ackWait - 1;
    end
    else if (dataAck && !dataReq)
    begin
      if (ackWait == 0)
      begin
        dataAck = 1'b0;
        ackWait = $random(seed) & 3;
      end
      else
        ackWait = ackWait - 1;
    end
    if (draining)
    begin
      decodeInstr  = '0;
      branchTakenE = 1'b0;
    end
    else
    begin
      // a held decode keeps its instruction and a flushed one fetches again
      if (expCtrl.flushD || !expCtrl.stallD)
        decodeInstr = randomInstr();
      rb           = $random(seed);
      branchTakenE = ((rb % 32'd10) == 32'd0);
    end
  endtask

  // four-phase order seen on the bus itself
  task automatic checkHandshakeOrder();
    if (dataReq && !prevReq)
    begin
      if (!isAccess(mMem))
        failRun("dataReq rose with no load or store waiting in the memory stage");
      if (reqSeenForEntry)
        failRun("dataReq rose a second time for the same memory-stage entry");
      reqSeenForEntry = 1'b1;
      accessCount     = accessCount + 1;
    end
    if (!dataReq && prevReq && !prevAck)
      failRun("dataReq fell before dataAck was seen high");
    prevReq = dataReq;
    prevAck = dataAck;
  endtask

  task automatic checkOutputs();
    hazardPkg::instrInfo_t oldest;
    computeExpected();
    checkFwd("forwardA", expFwdA, forwardA);
    checkFwd("forwardB", expFwdB, forwardB);
    checkCtrl("ctrl", expCtrl, ctrl);
    checkBit("dataReq", expReq, dataReq);
    checkInstr("retireInstr", mWb, retireInstr);
    checkHandshakeOrder();
    if (retireInstr.valid)
    begin
      if (retireQ.size() == 0)
        failRun("an instruction retired that never entered execute");
      oldest = retireQ.pop_front();
      checkInstr("retire order", oldest, retireInstr);
      retireCount = retireCount + 1;
    end
    if (expLoadUse && !expBusy)
      loadUseCount = loadUseCount + 1;
    if (expCtrl.flushD)
      branchCount = branchCount + 1;
  endtask

  task automatic runCycle();
    @(posedge clk);
    advanceModel();
    @(negedge clk);
    driveInputs();
    // outputs settle well before the next rising edge
    #2;
    checkOutputs();
  endtask

  initial
  begin
    clk             = 1'b0;
    arstN           = 1'b0;
    decodeInstr     = '0;
    branchTakenE    = 1'b0;
    dataAck         = 1'b0;
    mEx             = '0;
    mMem            = '0;
    mWb             = '0;
    mHs             = hazardPkg::hsIdle;
    ackWait         = 0;
    prevReq         = 1'b0;
    prevAck         = 1'b0;
    reqSeenForEntry = 1'b0;
    draining        = 1'b0;
    loadUseCount    = 0;
    branchCount     = 0;
    accessCount     = 0;
    retireCount     = 0;
    testName        = "reset";
    repeat (ResetCycles) @(negedge clk);
    arstN = 1'b1;
    #2;
    // idle pipe right after reset
    checkOutputs();
    checkFwd("forwardA", hazardPkg::fwdNone, forwardA);
    checkFwd("forwardB", hazardPkg::fwdNone, forwardB);
    checkCtrl("ctrl", '0, ctrl);
    checkBit("dataReq", 1'b0, dataReq);
    checkBit("retire valid", 1'b0, retireInstr.valid);

    testName = "random";
    repeat (NumCycles) runCycle();

    // stop issuing and let everything in flight retire
    testName = "drain";
    draining = 1'b1;
    while (retireQ.size() != 0)
      runCycle();

    if (loadUseCount == 0)
      failRun("random stimulus never produced a load-use stall");
    else if (branchCount == 0)
      failRun("random stimulus never produced a taken-branch flush");
    else if (accessCount == 0)
      failRun("random stimulus never produced a data access");
    else if (retireCount == 0)
      failRun("no instruction retired during the run");
    else
    begin
      $display("TESTS PASSED");
      $finish;
    end
  end

  // watchdog allows twice the length of the random run
  initial
  begin
    #(NumCycles * ClkPeriod * 2);
    failRun("timeout, the test did not finish in the allowed time");
  end

endmodule

//--- logic/hazardTop.sv
`timescale 1ns/1ps

// hazard control block of the five-stage pipe
// forward selects leave directly, ctrl also steers the stage tracker
module hazardTop (
  input  logic                  clk,
  input  logic                  arstN,
  input  hazardPkg::instrInfo_t decodeInstr,
  input  logic                  branchTakenE,
  input  logic                  dataAck,
  output hazardPkg::fwdSel_e    forwardA,
  output hazardPkg::fwdSel_e    forwardB,
  output hazardPkg::pipeCtrl_t  ctrl,
  output logic                  dataReq,
  output hazardPkg::instrInfo_t retireInstr
);

  // downstream entries held by the tracker
  hazardPkg::instrInfo_t exInstr;
  hazardPkg::instrInfo_t memInstr;
  hazardPkg::instrInfo_t wbInstr;

  // data access open on the memory port
  logic memBusy;
  // memory stage moves on this cycle
  logic memAdvance;

  assign memAdvance  = !ctrl.stallM;
  assign retireInstr = wbInstr;

  stageTracker stageTracker_i (
    .clk         (clk),
    .arstN       (arstN),
    .decodeInstr (decodeInstr),
    .ctrl        (ctrl),
    .exInstr     (exInstr),
    .memInstr    (memInstr),
    .wbInstr     (wbInstr)
  );

  forwardUnit forwardUnit_i (
    .exInstr  (exInstr),
    .memInstr (memInstr),
    .wbInstr  (wbInstr),
    .forwardA (forwardA),
    .forwardB (forwardB)
  );

  stallUnit stallUnit_i (
    .decodeInstr  (decodeInstr),
    .exInstr      (exInstr),
    .branchTakenE (branchTakenE),
    .memBusy      (memBusy),
    .ctrl         (ctrl)
  );

  memHandshake memHandshake_i (
    .clk        (clk),
    .arstN      (arstN),
    .memInstr   (memInstr),
    .memAdvance (memAdvance),
    .dataAck    (dataAck),
    .dataReq    (dataReq),
    .memBusy    (memBusy)
  );

endmodule

//--- logic/memHandshake.sv
`timescale 1ns/1ps

// four-phase req/ack sequencer for the memory-stage data access
// one transfer per memory entry, then waits for the stage to advance
module memHandshake (
  input  logic                  clk,
  input  logic                  arstN,
  input  hazardPkg::instrInfo_t memInstr,
  input  logic                  memAdvance,
  input  logic                  dataAck,
  output logic                  dataReq,
  output logic                  memBusy
);

  hazardPkg::hsState_e state;
  hazardPkg::hsState_e stateNext;

  // memory entry needs the data port
  logic accessPending;

  assign accessPending = memInstr.valid && (memInstr.memRead || memInstr.memWrite);

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      state <= hazardPkg::hsIdle;
    else
      state <= stateNext;
  end

  always_comb
  begin
    stateNext = state;
    unique case (state)
      hazardPkg::hsIdle:
      begin
        // start as soon as a load or store sits in memory
        if (accessPending)
          stateNext = hazardPkg::hsReq;
      end
      hazardPkg::hsReq:
      begin
        // req stays up until ack is seen high
        if (dataAck)
          stateNext = hazardPkg::hsRelease;
      end
      hazardPkg::hsRelease:
      begin
        // req is down, wait for ack to return low
        if (!dataAck)
          stateNext = hazardPkg::hsDone;
      end
      hazardPkg::hsDone:
      begin
        // access finished, never repeat it for the same entry
        if (memAdvance)
          stateNext = hazardPkg::hsIdle;
      end
      default:
      begin
        stateNext = hazardPkg::hsIdle;
      end
    endcase
  end

  // req comes straight from the state, glitch free on the bus
  assign dataReq = (state == hazardPkg::hsReq);

  // busy from the first cycle of the access through the release phase
  // hsIdle term keeps the pipe from moving the entry before req rises
  assign memBusy = ((state == hazardPkg::hsIdle) && accessPending) ||
                   (state == hazardPkg::hsReq) ||
                   (state == hazardPkg::hsRelease);

endmodule

//--- logic/stallUnit.sv
`timescale 1ns/1ps

// load-use detection and the stall/flush vector
module stallUnit (
  input  hazardPkg::instrInfo_t decodeInstr,
  input  hazardPkg::instrInfo_t exInstr,
  input  logic                  branchTakenE,
  input  logic                  memBusy,
  output hazardPkg::pipeCtrl_t  ctrl
);

  // load in execute whose result decode wants next cycle
  logic loadUse;
  // decode reads the register the load writes
  logic srcMatch;

  // a zero destination never creates a dependency
  always_comb
  begin
    srcMatch = (exInstr.dst == decodeInstr.src1) ||
               (exInstr.dst == decodeInstr.src2);
    loadUse  = decodeInstr.valid && exInstr.valid && exInstr.memRead &&
               (exInstr.dst != '0) && srcMatch;
  end

  // memory stalls dominate everything else
  // held stages are never flushed, the flush waits until memory is free
  always_comb
  begin
    // front end holds on a load-use bubble or an open data access
    ctrl.stallF = loadUse || memBusy;
    ctrl.stallD = loadUse || memBusy;

    // back end holds only for the data port
    ctrl.stallE = memBusy;
    ctrl.stallM = memBusy;

    // writeback gets bubbles while memory is held
    ctrl.flushW = memBusy;

    // Wrong-path instructions in decode and execute are squashed on a taken branch.
    ctrl.flushD = branchTakenE && !memBusy;
    ctrl.flushE = (loadUse || branchTakenE) && !memBusy;
  end

endmodule

//--- logic/forwardUnit.sv
`timescale 1ns/1ps

// operand forwarding selects for the two execute-stage sources
module forwardUnit (
  input  hazardPkg::instrInfo_t exInstr,
  input  hazardPkg::instrInfo_t memInstr,
  input  hazardPkg::instrInfo_t wbInstr,
  output hazardPkg::fwdSel_e    forwardA,
  output hazardPkg::fwdSel_e    forwardB
);

  // true when a downstream entry writes the register that src reads
  // register 0 is hardwired, never a source of forwarding
  function automatic logic writesReg(
    input hazardPkg::instrInfo_t entry,
    input logic [hazardPkg::RegIdxW-1:0] src
  );
    writesReg = entry.valid && entry.regWrite &&
                (entry.dst != '0) && (entry.dst == src);
  endfunction

  // priority chain, newest result first
  function automatic hazardPkg::fwdSel_e pickSrc(
    input logic [hazardPkg::RegIdxW-1:0] src
  );
    if (writesReg(memInstr, src))
      pickSrc = hazardPkg::fwdMem;
    else if (writesReg(wbInstr, src))
      pickSrc = hazardPkg::fwdWb;
    else
      pickSrc = hazardPkg::fwdNone;
  endfunction

  // selects are purely combinational, same cycle as the tracker state
  always_comb
  begin
    forwardA = pickSrc(exInstr.src1);
    forwardB = pickSrc(exInstr.src2);
  end

endmodule

//--- logic/stageTracker.sv
`timescale 1ns/1ps

// holds the register fields of the execute, memory and writeback entries
// stands in for the datapath pipeline registers
module stageTracker (
  input  logic                  clk,
  input  logic                  arstN,
  input  hazardPkg::instrInfo_t decodeInstr,
  input  hazardPkg::pipeCtrl_t  ctrl,
  output hazardPkg::instrInfo_t exInstr,
  output hazardPkg::instrInfo_t memInstr,
  output hazardPkg::instrInfo_t wbInstr
);

  // execute entry
  // held while the memory stage waits on the data port
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      exInstr <= '0;
    end
    else if (ctrl.stallE)
    begin
      // keep the instruction until memory is free
      exInstr <= exInstr;
    end
    else if (ctrl.flushE || ctrl.stallD)
    begin
      // load-use or taken branch puts a bubble into execute
      // payload fields are left as they were
      exInstr       <= decodeInstr;
      exInstr.valid <= 1'b0;
    end
    else
    begin
      exInstr <= decodeInstr;
    end
  end

  // memory entry
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      memInstr <= '0;
    end
    else if (ctrl.stallM)
    begin
      // access still open on the data port
      memInstr <= memInstr;
    end
    else
    begin
      memInstr <= exInstr;
    end
  end

  // writeback entry
  // a held memory stage sends bubbles so nothing retires twice
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      wbInstr <= '0;
    end
    else if (ctrl.stallM || ctrl.flushW)
    begin
      wbInstr       <= memInstr;
      wbInstr.valid <= 1'b0;
    end
    else
    begin
      wbInstr <= memInstr;
    end
  end

endmodule

//--- logic/hazardPkg.sv
package hazardPkg;

  // register file index width, 32 architectural registers
  localparam int RegIdxW = 5;

  // register fields of one instruction as it moves down the pipe
  typedef struct packed {
    // entry holds a real instruction, cleared for a bubble
    logic               valid;
    // first source operand
    logic [RegIdxW-1:0] src1;
    // second source operand
    logic [RegIdxW-1:0] src2;
    // destination register
    logic [RegIdxW-1:0] dst;
    // result is written back to dst
    logic               regWrite;
    // load, the result only exists after the memory stage
    logic               memRead;
    // store
    logic               memWrite;
  } instrInfo_t;

  // operand source chosen for an execute-stage input
  // memory result is newer than writeback, so it has priority
  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdWb   = 2'b01,
    fwdMem  = 2'b10
  } fwdSel_e;

  // stall and flush vector for the whole pipe
  typedef struct packed {
    // hold the fetch PC
    logic stallF;
    // hold the decode register
    logic stallD;
    // hold the execute entry
    logic stallE;
    // hold the memory entry
    logic stallM;
    // squash the instruction in decode
    logic flushD;
    // put a bubble into execute
    logic flushE;
    // put a bubble into writeback
    logic flushW;
  } pipeCtrl_t;

  // phases of one four-phase req/ack transfer
  typedef enum logic [1:0] {
    hsIdle    = 2'b00,
    hsReq     = 2'b01,
    hsRelease = 2'b10,
    hsDone    = 2'b11
  } hsState_e;

endpackage
